//--- logic/stream_source_pkg.sv
/*
  Widths and port count for the stream source. All accesses are word aligned,
  so a beat covers NB_PORTS consecutive words in memory.
*/
package stream_source_pkg;

  // memory side
  localparam int unsigned NB_PORTS   = 2;
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned WORD_BYTES = WORD_WIDTH / 8;
  localparam int unsigned ADDR_WIDTH = 32; // byte address

  // stream side
  localparam int unsigned DATA_WIDTH = NB_PORTS * WORD_WIDTH;

  // transfer size, line length and beat counters
  localparam int unsigned CNT_WIDTH  = 16;

  // address step from one beat to the next inside a line
  localparam int unsigned BEAT_BYTES = NB_PORTS * WORD_BYTES;

  // control FSM
  typedef enum logic [0:0] {
    SRC_IDLE,    // waiting for a start request
    SRC_WORKING  // issuing beats until the last one is granted
  } source_state_e;

endpackage

//--- logic/source_addr_gen.sv
/*
  2D address walk: lines of line_length beats, line_stride bytes apart.
  trans_size must be at least 1; the configuration is latched at start_i.
*/
`timescale 1ns/100ps

module source_addr_gen (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 start_i,
  input  logic                                 enable_i,
  input  logic [stream_source_pkg::ADDR_WIDTH-1:0] base_addr_i,
  input  logic [stream_source_pkg::CNT_WIDTH-1:0]  trans_size_i,
  input  logic [stream_source_pkg::CNT_WIDTH-1:0]  line_length_i,
  input  logic [stream_source_pkg::ADDR_WIDTH-1:0] line_stride_i,
  output logic [stream_source_pkg::ADDR_WIDTH-1:0] addr_o,
  output logic                                 last_beat_o
);

  import stream_source_pkg::*;

  logic [CNT_WIDTH-1:0]  trans_size_q;
  logic [CNT_WIDTH-1:0]  line_length_q;
  logic [ADDR_WIDTH-1:0] line_stride_q;

  logic [CNT_WIDTH-1:0]  beat_cnt_q;   // beats issued so far
  logic [CNT_WIDTH-1:0]  pos_cnt_q;    // position inside the line
  logic [ADDR_WIDTH-1:0] line_base_q;  // address of the current line
  logic [ADDR_WIDTH-1:0] pos_off_q;    // pos_cnt_q * BEAT_BYTES

  logic end_of_line;

  assign end_of_line = (pos_cnt_q == line_length_q - 1'b1);

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      trans_size_q  <= trans_size_i;
      line_length_q <= line_length_i;
      line_stride_q <= line_stride_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q  <= '0;
      pos_cnt_q   <= '0;
      line_base_q <= '0;
      pos_off_q   <= '0;
    end else if (start_i) begin
      beat_cnt_q  <= '0;
      pos_cnt_q   <= '0;
      line_base_q <= base_addr_i;
      pos_off_q   <= '0;
    end else if (clear_i) begin
      beat_cnt_q <= '0;
      pos_cnt_q  <= '0;
      pos_off_q  <= '0;
    end else if (enable_i) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      if (end_of_line) begin // wrap to next line
        pos_cnt_q   <= '0;
        pos_off_q   <= '0;
        line_base_q <= line_base_q + line_stride_q;
      end else begin
        pos_cnt_q <= pos_cnt_q + 1'b1;
        pos_off_q <= pos_off_q + ADDR_WIDTH'(BEAT_BYTES);
      end
    end
  end

  assign addr_o      = line_base_q + pos_off_q;
  assign last_beat_o = (beat_cnt_q == trans_size_q - 1'b1);

  // the FSM must stop advancing once every beat has been issued
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    enable_i |-> beat_cnt_q < trans_size_q);

endmodule

//--- logic/tcdm_read_bank.sv
/*
  Splits each beat into NB_PORTS word reads and merges the returned words.
  Assumes r_valid exactly one cycle after the grant; one beat in flight at a time.
*/
`timescale 1ns/100ps

module tcdm_read_bank (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  input  logic                                           beat_req_i,
  input  logic [stream_source_pkg::ADDR_WIDTH-1:0]           beat_addr_i,
  output logic                                           beat_gnt_o,
  output logic                                           idle_o,
  output logic [stream_source_pkg::NB_PORTS-1:0]             tcdm_req_o,
  output logic [stream_source_pkg::NB_PORTS*stream_source_pkg::ADDR_WIDTH-1:0] tcdm_addr_o,
  input  logic [stream_source_pkg::NB_PORTS-1:0]             tcdm_gnt_i,
  input  logic [stream_source_pkg::NB_PORTS-1:0]             tcdm_r_valid_i,
  input  logic [stream_source_pkg::NB_PORTS*stream_source_pkg::WORD_WIDTH-1:0] tcdm_r_data_i,
  output logic                                           stream_valid_o,
  output logic [stream_source_pkg::DATA_WIDTH-1:0]           stream_data_o,
  input  logic                                           stream_ready_i
);

  import stream_source_pkg::*;

  logic [NB_PORTS-1:0] gnt_mask_q;  // port already granted for this beat
  logic [NB_PORTS-1:0] port_hs;     // request and grant this cycle
  logic [NB_PORTS-1:0] port_done;
  logic [NB_PORTS-1:0] pend_q;      // read data due this cycle
  logic [NB_PORTS-1:0] full_q;
  logic                stream_hs;

  assign tcdm_req_o = {NB_PORTS{beat_req_i}} & ~gnt_mask_q;
  assign port_hs    = tcdm_req_o & tcdm_gnt_i;
  assign port_done  = gnt_mask_q | port_hs;
  assign beat_gnt_o = beat_req_i & (&port_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_mask_q <= '0;
    end else if (clear_i || beat_gnt_o) begin
      gnt_mask_q <= '0;
    end else begin
      gnt_mask_q <= gnt_mask_q | port_hs;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else if (clear_i) begin
      pend_q <= '0; // drops reads already granted
    end else begin
      pend_q <= port_hs;
    end
  end

  assign stream_valid_o = &full_q;
  assign stream_hs      = stream_valid_o & stream_ready_i;
  assign idle_o         = ~|(full_q | pend_q);

  for (genvar p = 0; p < NB_PORTS; p++) begin : gen_port
    logic [WORD_WIDTH-1:0] data_q;
    logic                  capture;

    assign tcdm_addr_o[p*ADDR_WIDTH +: ADDR_WIDTH] = beat_addr_i + ADDR_WIDTH'(p*WORD_BYTES);
    assign capture = tcdm_r_valid_i[p] & pend_q[p];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        full_q[p] <= 1'b0;
      end else if (clear_i) begin
        full_q[p] <= 1'b0;
      end else if (capture) begin
        full_q[p] <= 1'b1;
      end else if (stream_hs) begin
        full_q[p] <= 1'b0; // all ports empty together
      end
    end

    always_ff @(posedge clk_i) begin
      if (capture) begin
        data_q <= tcdm_r_data_i[p*WORD_WIDTH +: WORD_WIDTH];
      end
    end

    assign stream_data_o[p*WORD_WIDTH +: WORD_WIDTH] = data_q;

    // the next beat may only be granted once this word has left
    assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
      tcdm_r_valid_i[p] |-> !full_q[p]);
  end

endmodule

//--- logic/source_ctrl_fsm.sv
/*
  Idle/working control of the source. A beat is started only when the stream is
  ready and the read bank is empty; once started it stays requested until granted.
*/
`timescale 1ns/100ps

module source_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic req_start_i,
  output logic ready_start_o,
  output logic done_o,
  input  logic stream_ready_i,
  input  logic bank_idle_i,
  input  logic beat_gnt_i,
  input  logic last_beat_i,
  output logic beat_req_o,
  output logic addr_start_o,
  output logic addr_en_o
);

  import stream_source_pkg::*;

  source_state_e state_q, state_d;

  logic req_pend_q; // beat started, grant still missing
  logic done_d;
  logic working;

  assign working = (state_q == SRC_WORKING);

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    case (state_q)
      SRC_IDLE: begin
        if (req_start_i) begin
          state_d = SRC_WORKING;
        end
      end
      SRC_WORKING: begin
        if (beat_gnt_i && last_beat_i) begin
          state_d = SRC_IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SRC_IDLE;
      req_pend_q <= 1'b0;
      done_o     <= 1'b0;
    end else if (clear_i) begin
      state_q    <= SRC_IDLE;
      req_pend_q <= 1'b0;
      done_o     <= 1'b0; // aborted, no done
    end else begin
      state_q    <= state_d;
      req_pend_q <= beat_req_o & ~beat_gnt_i;
      done_o     <= done_d;
    end
  end

  assign ready_start_o = (state_q == SRC_IDLE);
  assign addr_start_o  = ready_start_o & req_start_i & ~clear_i;

  assign beat_req_o = working & ~clear_i & (req_pend_q | (stream_ready_i & bank_idle_i));
  assign addr_en_o  = working & beat_gnt_i;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o);

endmodule

//--- logic/stream_source.sv
/*
  Memory-to-stream source: reads a 2D block over NB_PORTS word ports and emits
  one wide beat per NB_PORTS words, in address order. Reads only, word aligned.
*/
`timescale 1ns/100ps

module stream_source (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  // control plane
  input  logic                                           req_start_i,
  input  logic [stream_source_pkg::ADDR_WIDTH-1:0]           base_addr_i,
  input  logic [stream_source_pkg::CNT_WIDTH-1:0]            trans_size_i,
  input  logic [stream_source_pkg::CNT_WIDTH-1:0]            line_length_i,
  input  logic [stream_source_pkg::ADDR_WIDTH-1:0]           line_stride_i,
  output logic                                           ready_start_o,
  output logic                                           done_o,
  // memory ports
  output logic [stream_source_pkg::NB_PORTS-1:0]             tcdm_req_o,
  output logic [stream_source_pkg::NB_PORTS*stream_source_pkg::ADDR_WIDTH-1:0] tcdm_addr_o,
  input  logic [stream_source_pkg::NB_PORTS-1:0]             tcdm_gnt_i,
  input  logic [stream_source_pkg::NB_PORTS-1:0]             tcdm_r_valid_i,
  input  logic [stream_source_pkg::NB_PORTS*stream_source_pkg::WORD_WIDTH-1:0] tcdm_r_data_i,
  // output stream
  output logic                                           stream_valid_o,
  output logic [stream_source_pkg::DATA_WIDTH-1:0]           stream_data_o,
  input  logic                                           stream_ready_i
);

  import stream_source_pkg::*;

  logic                  beat_req;
  logic                  beat_gnt;
  logic                  bank_idle;
  logic                  addr_en;
  logic                  addr_clr;  // start of a new walk
  logic [ADDR_WIDTH-1:0] gen_addr;
  logic                  last_beat;

  source_addr_gen i_addr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( clear_i       ),
    .start_i       ( addr_clr      ),
    .enable_i      ( addr_en       ),
    .base_addr_i   ( base_addr_i   ),
    .trans_size_i  ( trans_size_i  ),
    .line_length_i ( line_length_i ),
    .line_stride_i ( line_stride_i ),
    .addr_o        ( gen_addr      ),
    .last_beat_o   ( last_beat     )
  );

  tcdm_read_bank i_read_bank (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .beat_req_i     ( beat_req       ),
    .beat_addr_i    ( gen_addr       ),
    .beat_gnt_o     ( beat_gnt       ),
    .idle_o         ( bank_idle      ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_addr_o    ( tcdm_addr_o    ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .tcdm_r_valid_i ( tcdm_r_valid_i ),
    .tcdm_r_data_i  ( tcdm_r_data_i  ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  ),
    .stream_ready_i ( stream_ready_i )
  );

  source_ctrl_fsm i_ctrl_fsm (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .req_start_i    ( req_start_i    ),
    .ready_start_o  ( ready_start_o  ),
    .done_o         ( done_o         ),
    .stream_ready_i ( stream_ready_i ),
    .bank_idle_i    ( bank_idle      ),
    .beat_gnt_i     ( beat_gnt       ),
    .last_beat_i    ( last_beat      ),
    .beat_req_o     ( beat_req       ),
    .addr_start_o   ( addr_clr       ),
    .addr_en_o      ( addr_en        )
  );

endmodule

//--- tests/tcdm_mem_model.sv
/*
  Behavioural read-only memory with NB_PORTS ports. The word at byte address a
  is a * 32'h9e3779b1 + 1; grants are random per port, data follows one cycle later.
*/
`timescale 1ns/100ps

module tcdm_mem_model (
  input  logic                                                               clk_i,
  input  logic                                                               rst_ni,
  input  logic [stream_source_pkg::NB_PORTS-1:0]                             req_i,
  input  logic [stream_source_pkg::NB_PORTS*stream_source_pkg::ADDR_WIDTH-1:0] addr_i,
  output logic [stream_source_pkg::NB_PORTS-1:0]                             gnt_o,
  output logic [stream_source_pkg::NB_PORTS-1:0]                             r_valid_o,
  output logic [stream_source_pkg::NB_PORTS*stream_source_pkg::WORD_WIDTH-1:0] r_data_o
);

  import stream_source_pkg::*;

  integer                         seed;
  logic [NB_PORTS-1:0]            gnt_en;  // per-port grant this cycle
  logic [NB_PORTS-1:0]            hs;
  logic [NB_PORTS*WORD_WIDTH-1:0] rdata;

  function automatic logic [WORD_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] addr);
    return addr * 32'h9e3779b1 + 32'd1; // low 32 bits only
  endfunction

  assign gnt_o = req_i & gnt_en;

  initial begin
    seed      = 32'h83f6;
    gnt_en    = '0;
    hs        = '0;
    rdata     = '0;
    r_valid_o = '0;
    r_data_o  = '0;
  end

  // sample the handshakes of the coming edge, answer just after it
  always @(negedge clk_i) begin
    hs = rst_ni ? (req_i & gnt_o) : '0;
    for (int p = 0; p < NB_PORTS; p++) begin
      if (hs[p]) begin
        rdata[p*WORD_WIDTH +: WORD_WIDTH] = word_at(addr_i[p*ADDR_WIDTH +: ADDR_WIDTH]);
      end
    end
    @(posedge clk_i);
    #1;
    r_valid_o = hs;
    r_data_o  = rdata;
    gnt_en    = NB_PORTS'($random(seed)); // about half of the ports grant
  end

endmodule

//--- tests/tb_stream_source.sv
/*
  Random 2D transfers under random grants and back-pressure, checked against a
  queue of expected beats. One transfer is aborted by clear_i.
*/
`timescale 1ns/100ps

module tb_stream_source;

  import stream_source_pkg::*;

  localparam int unsigned NB_TRANSFERS   = 20;
  localparam int unsigned MAX_SIZE       = 24;
  localparam int unsigned ABORT_IDX      = 9;
  localparam int unsigned TIMEOUT_CYCLES = NB_TRANSFERS * MAX_SIZE * 40 + 500;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           clear_i;
  logic                           req_start_i;
  logic [ADDR_WIDTH-1:0]          base_addr_i;
  logic [CNT_WIDTH-1:0]           trans_size_i;
  logic [CNT_WIDTH-1:0]           line_length_i;
  logic [ADDR_WIDTH-1:0]          line_stride_i;
  logic                           ready_start_o;
  logic                           done_o;
  logic [NB_PORTS-1:0]            tcdm_req_o;
  logic [NB_PORTS*ADDR_WIDTH-1:0] tcdm_addr_o;
  logic [NB_PORTS-1:0]            tcdm_gnt_i;
  logic [NB_PORTS-1:0]            tcdm_r_valid_i;
  logic [NB_PORTS*WORD_WIDTH-1:0] tcdm_r_data_i;
  logic                           stream_valid_o;
  logic [DATA_WIDTH-1:0]          stream_data_o;
  logic                           stream_ready_i;

  integer                seed;
  int                    err_cnt;
  int                    cur_size;    // beats of the running transfer
  int                    req_beat;    // beats fully granted so far
  int                    beats_out;   // beats accepted on the stream
  int                    done_cnt;
  bit                    busy;
  bit                    clear_seen;
  bit                    prev_valid;
  bit                    prev_hs;
  logic [DATA_WIDTH-1:0] prev_data;
  logic [DATA_WIDTH-1:0] exp_beat;
  logic [ADDR_WIDTH-1:0] exp_port_addr;
  logic [NB_PORTS-1:0]   gnt_seen;
  logic [ADDR_WIDTH-1:0] exp_addr [MAX_SIZE];
  logic [DATA_WIDTH-1:0] exp_data [$];

  stream_source stream_source_i (.*);

  tcdm_mem_model i_mem_model (
    .clk_i     ( clk_i          ),
    .rst_ni    ( rst_ni         ),
    .req_i     ( tcdm_req_o     ),
    .addr_i    ( tcdm_addr_o    ),
    .gnt_o     ( tcdm_gnt_i     ),
    .r_valid_o ( tcdm_r_valid_i ),
    .r_data_o  ( tcdm_r_data_i  )
  );

  function automatic logic [WORD_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
    return addr * 32'h9e3779b1 + 32'd1;
  endfunction

  // beat k sits in line k / len at position k % len
  task automatic load_expected(input logic [ADDR_WIDTH-1:0] base, input int n_beats,
                               input int len, input logic [ADDR_WIDTH-1:0] stride);
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] beat;
    for (int k = 0; k < n_beats; k++) begin
      addr = base + (k / len) * stride + (k % len) * BEAT_BYTES;
      exp_addr[k] = addr;
      for (int p = 0; p < NB_PORTS; p++) begin
        beat[p*WORD_WIDTH +: WORD_WIDTH] = mem_word(addr + 4 * p);
      end
      exp_data.push_back(beat);
    end
  endtask

  task automatic run_transfer(input int idx, input bit abort);
    int                    n_beats;
    int                    len;
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] stride;
    n_beats = abort ? MAX_SIZE : 1 + {$random(seed)} % MAX_SIZE;
    len     = 1 + {$random(seed)} % 6;
    stride  = 8 * ({$random(seed)} % 32);
    base    = $random(seed) & 32'h000f_fffc;
    load_expected(base, n_beats, len, stride);
    @(posedge clk_i);
    #1;
    cur_size      = n_beats;
    req_beat      = 0;
    beats_out     = 0;
    done_cnt      = 0;
    gnt_seen      = '0;
    req_start_i   = 1'b1;
    base_addr_i   = base;
    trans_size_i  = CNT_WIDTH'(n_beats);
    line_length_i = CNT_WIDTH'(len);
    line_stride_i = stride;
    @(posedge clk_i);
    #1 req_start_i = 1'b0;
    if (abort) begin
      while (beats_out < 2) @(posedge clk_i);
      #1 clear_i = 1'b1;
      @(posedge clk_i);
      #1 clear_i = 1'b0;
      repeat (4) @(posedge clk_i);
    end else begin
      while (done_cnt == 0 || exp_data.size() != 0) @(posedge clk_i);
      repeat (4) @(posedge clk_i); // catches extra beats
      assert (done_cnt == 1) else begin
        err_cnt++;
        $display("transfer %0d: done_o pulsed %0d times", idx, done_cnt);
      end
      assert (beats_out == n_beats) else begin
        err_cnt++;
        $display("transfer %0d: %0d beats left the stream, %0d expected", idx, beats_out, n_beats);
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    #1;
    stream_ready_i = ($random(seed) & 3) != 0; // ready about 3 cycles in 4
  end

  // all outputs sampled mid-cycle, where they are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (prev_valid && !prev_hs && !clear_seen) begin
        assert (stream_valid_o) else begin
          err_cnt++;
          $display("** Error stream_valid_o: expected 1, got %h under back-pressure", stream_valid_o);
        end
        assert (stream_data_o == prev_data) else begin
          err_cnt++;
          $display("** Error stream_data_o: expected %h, got %h under back-pressure",
                   prev_data, stream_data_o);
        end
      end
      if (stream_valid_o && stream_ready_i) begin
        if (exp_data.size() == 0) begin
          err_cnt++;
          $display("extra beat %h on the stream, none was expected", stream_data_o);
        end else begin
          exp_beat = exp_data.pop_front();
          beats_out++;
          assert (stream_data_o == exp_beat) else begin
            err_cnt++;
            $display("** Error stream_data_o: expected %h, got %h", exp_beat, stream_data_o);
          end
        end
      end
      for (int p = 0; p < NB_PORTS; p++) begin
        if (tcdm_req_o[p] && (!busy || req_beat >= cur_size)) begin
          err_cnt++;
          $display("port %0d requested memory with no beat outstanding", p);
        end else if (tcdm_req_o[p]) begin
          exp_port_addr = exp_addr[req_beat] + 4 * p;
          assert (tcdm_addr_o[p*ADDR_WIDTH +: ADDR_WIDTH] == exp_port_addr) else begin
            err_cnt++;
            $display("** Error tcdm_addr_o[%0d]: expected %h, got %h", p, exp_port_addr,
                     tcdm_addr_o[p*ADDR_WIDTH +: ADDR_WIDTH]);
          end
        end
      end
      gnt_seen = gnt_seen | (tcdm_req_o & tcdm_gnt_i);
      if (&gnt_seen) begin // beat granted on every port
        req_beat++;
        gnt_seen = '0;
      end
      if (busy && !done_o) begin
        assert (!ready_start_o) else begin
          err_cnt++;
          $display("ready_start_o high while a transfer is running");
        end
      end
      if (clear_seen) begin
        assert (ready_start_o) else begin
          err_cnt++;
          $display("ready_start_o low in the cycle after clear_i");
        end
      end
      if (done_o && busy && req_beat == cur_size) begin
        done_cnt++;
      end else if (done_o) begin
        err_cnt++;
        $display("done_o pulsed with %0d of %0d beats granted", req_beat, cur_size);
      end
      if (done_o) busy = 1'b0;
      if (req_start_i && ready_start_o && !clear_i) busy = 1'b1;
      if (clear_i) begin
        busy     = 1'b0;
        gnt_seen = '0;
        exp_data.delete();
      end
      prev_valid = stream_valid_o;
      prev_hs    = stream_valid_o & stream_ready_i;
      prev_data  = stream_data_o;
      clear_seen = clear_i;
    end
  end

  initial begin
    seed           = 32'h83f6;
    err_cnt        = 0;
    cur_size       = 0;
    req_beat       = 0;
    beats_out      = 0;
    done_cnt       = 0;
    busy           = 1'b0;
    clear_seen     = 1'b0;
    prev_valid     = 1'b0;
    prev_hs        = 1'b0;
    prev_data      = '0;
    gnt_seen       = '0;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    req_start_i    = 1'b0;
    base_addr_i    = '0;
    trans_size_i   = '0;
    line_length_i  = '0;
    line_stride_i  = '0;
    stream_ready_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    assert (ready_start_o && !stream_valid_o && !done_o && tcdm_req_o == '0) else begin
      err_cnt++;
      $display("outputs not at their reset values after reset");
    end
    for (int t = 0; t < NB_TRANSFERS; t++) begin
      run_transfer(t, t == ABORT_IDX);
    end
    repeat (5) @(posedge clk_i);
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("run did not finish in %0d cycles, %0d expected beats never arrived",
             TIMEOUT_CYCLES, exp_data.size());
    $display("errors: %0d, plus a timeout", err_cnt);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- verilog.f
logic/stream_source_pkg.sv
logic/source_addr_gen.sv
logic/tcdm_read_bank.sv
logic/source_ctrl_fsm.sv
logic/stream_source.sv
tests/tcdm_mem_model.sv
tests/tb_stream_source.sv

//--- Bender.yml
package:
  name: stream_source

sources:
  # RTL, in compile order
  - files:
      - logic/stream_source_pkg.sv
      - logic/source_addr_gen.sv
      - logic/tcdm_read_bank.sv
      - logic/source_ctrl_fsm.sv
      - logic/stream_source.sv

  # testbench and memory model
  - target: test
    files:
      - tests/tcdm_mem_model.sv
      - tests/tb_stream_source.sv
